//--- src.f
+incdir+design
design/bridge_pkg.sv
design/uart_link.sv
design/char_decoder.sv
design/command_engine.sv
design/byte_fifo.sv
design/response_formatter.sv
design/ascii_bridge.sv
sim/tb_ascii_bridge.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert
TOP       = tb_ascii_bridge
FILELIST  = src.f
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- sim/tb_ascii_bridge.sv
`timescale 1ns/100ps
`default_nettype none
`include "bridge_config.svh"

module tb_ascii_bridge import bridge_pkg::*; ();

	logic       clk;
	logic       reset;
	logic       rxd;
	logic       txd;
	logic [7:0] tgt_byte;
	cmd_kind_t  tgt_kind;
	logic       tgt_byte_valid;
	logic       tgt_msg_end;
	logic [7:0] rsp_byte;
	logic       rsp_valid;
	logic       rsp_end;

	// Target events are {end flag, kind, byte}
	logic [10:0] exp_evt[$];
	logic [10:0] obs_evt[$];
	logic [7:0]  line_q[$];
	logic [7:0]  exp_line[$];
	logic [7:0]  tx_chars[$];
	logic [7:0]  mon_char;

	int errors = 0;
	int checks = 0;
	int test_start_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int exp_ends = 0;
	int obs_ends = 0;
	int char_budget = 0;
	int cycles = 0;

	// Reference model of the command line parser
	logic       model_active = 1'b0;
	logic       model_half = 1'b0;
	logic [3:0] model_hi = 4'h0;
	cmd_kind_t  model_kind = CMD_WRITE;

	ascii_bridge u_dut (
		.clk(clk), .reset(reset), .rxd(rxd), .txd(txd),
		.tgt_byte(tgt_byte), .tgt_kind(tgt_kind),
		.tgt_byte_valid(tgt_byte_valid), .tgt_msg_end(tgt_msg_end),
		.rsp_byte(rsp_byte), .rsp_valid(rsp_valid), .rsp_end(rsp_end)
	);

	always #5 clk = ~clk;

	// Budget of 10 bits per character with a margin of two
	always @(posedge clk) begin
		cycles++;
		if (cycles > (char_budget + 4) * 10 * `BAUD_DIV * 2) begin
			$display("Timeout: no progress from the DUT after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// Target side monitor
	always @(posedge clk) begin
		if (!reset && tgt_byte_valid)
			obs_evt.push_back({1'b0, tgt_kind, tgt_byte});
		if (!reset && tgt_msg_end) begin
			obs_evt.push_back(11'h400);
			obs_ends++;
		end
	end

	// Host side receiver on txd samples at mid-bit
	always begin
		@(posedge clk);
		if (!reset && txd === 1'b0) begin
			repeat (`BAUD_DIV / 2 - 1) @(posedge clk);
			for (int i = 0; i < 8; i++) begin
				repeat (`BAUD_DIV) @(posedge clk);
				mon_char = {txd, mon_char[7:1]};
			end
			repeat (`BAUD_DIV) @(posedge clk);
			if (txd !== 1'b1) begin
				$display("Framing error: stop bit low on txd at %0t", $time);
				errors++;
			end else begin
				tx_chars.push_back(mon_char);
			end
		end
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start_errors) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed", tests_run, name);
		end
		test_start_errors = errors;
	endtask

	function automatic int digit_value(input logic [7:0] ch);
		if (ch >= 8'h30 && ch <= 8'h39)
			return int'(ch) - 48;
		if (ch >= 8'h61 && ch <= 8'h66)
			return int'(ch) - 87;
		if (ch >= 8'h41 && ch <= 8'h46)
			return int'(ch) - 55;
		return -1;
	endfunction

	function automatic logic [7:0] digit_char(input logic [3:0] v, input logic upper);
		if (v < 4'd10)
			return 8'h30 + {4'h0, v};
		// Lower-case a and c are command letters
		if (upper || v == 4'd10 || v == 4'd12)
			return 8'h41 + {4'h0, v} - 8'd10;
		return 8'h61 + {4'h0, v} - 8'd10;
	endfunction

	function automatic logic [7:0] hex_lower(input logic [3:0] v);
		if (v < 4'd10)
			return 8'h30 + {4'h0, v};
		return 8'h61 + {4'h0, v} - 8'd10;
	endfunction

	function automatic logic [7:0] kind_letter(input int k);
		case (k)
			0: return "w";
			1: return "c";
			default: return "a";
		endcase
	endfunction

	function automatic logic [7:0] noise_char(input int k);
		case (k)
			0: return " ";
			1: return "x";
			2: return "G";
			3: return 8'h0d;
			default: return "W";
		endcase
	endfunction

	task automatic model_char(input logic [7:0] ch);
		int v;
		v = digit_value(ch);
		if (ch == "w" || ch == "c" || ch == "a") begin
			model_active = 1'b1;
			model_half = 1'b0;
			model_kind = (ch == "w") ? CMD_WRITE : (ch == "c") ? CMD_CTRL : CMD_ADDR;
		end else if (!model_active) begin
			// Nothing counts before a command letter
		end else if (v >= 0) begin
			if (model_half)
				exp_evt.push_back({1'b0, model_kind, model_hi, 4'(v)});
			else
				model_hi = 4'(v);
			model_half = !model_half;
		end else if (ch == `CHAR_LF) begin
			if (model_half)
				exp_evt.push_back({1'b0, model_kind, model_hi, 4'h0});
			exp_evt.push_back(11'h400);
			exp_ends++;
			model_active = 1'b0;
			model_half = 1'b0;
		end
	endtask

	// 8N1 frame with one bit every BAUD_DIV clocks
	task automatic send_serial(input logic [7:0] ch);
		logic [9:0] frame;
		frame = {1'b1, ch, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rxd = frame[0];
			frame = frame >> 1;
			repeat (`BAUD_DIV) @(posedge clk);
			#1;
		end
	endtask

	task automatic send_line();
		logic [7:0] ch;
		while (line_q.size() > 0) begin
			ch = line_q.pop_front();
			model_char(ch);
			char_budget++;
			send_serial(ch);
		end
	endtask

	task automatic add_digits(input int n, input logic mixed);
		for (int i = 0; i < n; i++)
			line_q.push_back(digit_char(4'($urandom_range(15)),
				mixed ? 1'($urandom_range(1)) : 1'b1));
	endtask

	task automatic finish_cmd_test(input string name);
		int idx;
		idx = 0;
		while (obs_ends < exp_ends)
			@(posedge clk);
		repeat (2) @(posedge clk);
		#1;
		check_value(32'(obs_evt.size()), 32'(exp_evt.size()), {name, " event count"});
		while (exp_evt.size() > 0 && obs_evt.size() > 0) begin
			check_value(32'(obs_evt.pop_front()), 32'(exp_evt.pop_front()),
				$sformatf("%s event %0d", name, idx));
			idx++;
		end
		exp_evt.delete();
		obs_evt.delete();
		end_test(name);
	endtask

	task automatic expect_char(input logic [7:0] ch);
		exp_line.push_back(ch);
		char_budget++;
	endtask

	// Target returns n random bytes and then marks the message end
	task automatic push_message(input int n);
		logic [7:0] b;
		for (int i = 0; i < n; i++) begin
			b = 8'($urandom_range(255));
			rsp_byte = b;
			rsp_valid = 1'b1;
			expect_char(hex_lower(b[7:4]));
			expect_char(hex_lower(b[3:0]));
			@(posedge clk);
			#1;
		end
		rsp_valid = 1'b0;
		rsp_end = 1'b1;
		@(posedge clk);
		#1;
		rsp_end = 1'b0;
	endtask

	task automatic check_response(input string name);
		int idx;
		idx = 0;
		while (tx_chars.size() < exp_line.size())
			@(posedge clk);
		@(posedge clk);
		#1;
		while (exp_line.size() > 0) begin
			check_value(32'(tx_chars.pop_front()), 32'(exp_line.pop_front()),
				$sformatf("%s char %0d", name, idx));
			idx++;
		end
		end_test(name);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		rxd = 1'b1;
		rsp_byte = 8'h00;
		rsp_valid = 1'b0;
		rsp_end = 1'b0;
		void'($urandom(32'h273f_7af3));
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (4) @(posedge clk);
		#1;

		for (int i = 0; i < 6; i++) begin
			line_q.push_back(kind_letter(int'($urandom_range(2))));
			add_digits(2 * int'($urandom_range(4, 1)), 1'b0);
			line_q.push_back(`CHAR_LF);
		end
		send_line();
		finish_cmd_test("even digit lines");

		// Stray digits ahead of any command are dropped
		line_q.push_back("3");
		line_q.push_back("4");
		line_q.push_back(`CHAR_LF);
		for (int i = 0; i < 4; i++) begin
			line_q.push_back(kind_letter(int'($urandom_range(2))));
			add_digits(2 * int'($urandom_range(3)) + 1, 1'b0);
			line_q.push_back(`CHAR_LF);
		end
		line_q.push_back("w");
		line_q.push_back(`CHAR_LF);
		line_q.push_back("c");
		line_q.push_back(`CHAR_LF);
		send_line();
		finish_cmd_test("odd and empty lines");

		for (int i = 0; i < 4; i++) begin
			line_q.push_back(kind_letter(int'($urandom_range(2))));
			for (int j = 0; j < 8; j++) begin
				if ($urandom_range(3) == 0)
					line_q.push_back(noise_char(int'($urandom_range(4))));
				else
					add_digits(1, 1'b1);
			end
			line_q.push_back(`CHAR_LF);
		end
		send_line();
		finish_cmd_test("mixed case and noise");

		for (int i = 0; i < 3; i++) begin
			line_q.push_back(kind_letter(int'($urandom_range(2))));
			add_digits(3, 1'b0);
			line_q.push_back(kind_letter(int'($urandom_range(2))));
			add_digits(2, 1'b0);
			line_q.push_back(`CHAR_LF);
		end
		send_line();
		finish_cmd_test("command in mid-line");

		for (int i = 0; i < 8; i++) begin
			expect_char(`RSP_PREFIX);
			push_message(int'($urandom_range(8)));
			expect_char(`CHAR_LF);
			check_response($sformatf("response %0d", i));
		end

		// Second message lands while the first line is on the wire
		expect_char(`RSP_PREFIX);
		push_message(5);
		while (tx_chars.size() < 3)
			@(posedge clk);
		#1;
		push_message(3);
		expect_char(`CHAR_LF);
		expect_char(`RSP_PREFIX);
		expect_char(`CHAR_LF);
		check_response("merged response");

		repeat (20 * `BAUD_DIV) @(posedge clk);
		check_value(32'(tx_chars.size()), 32'd0, "extra txd characters");
		check_value(32'(obs_evt.size()), 32'd0, "extra target events");
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/ascii_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module ascii_bridge import bridge_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       rxd,
	output logic       txd,
	output logic [7:0] tgt_byte,
	output cmd_kind_t  tgt_kind,
	output logic       tgt_byte_valid,
	output logic       tgt_msg_end,
	input  logic [7:0] rsp_byte,
	input  logic       rsp_valid,
	input  logic       rsp_end
);

	logic [7:0] rx_data;
	logic       rx_valid;
	logic [7:0] tx_data;
	logic       tx_start;
	logic       tx_busy;
	logic       is_hex;
	logic [3:0] hex_val;
	logic       is_cmd;
	cmd_kind_t  cmd_kind;
	logic       is_eol;
	logic [7:0] rd_data;
	logic       rd_en;
	logic       empty;

	uart_link u_uart (
		.clk(clk), .reset(reset), .rxd(rxd), .txd(txd),
		.rx_data(rx_data), .rx_valid(rx_valid),
		.tx_data(tx_data), .tx_start(tx_start), .tx_busy(tx_busy)
	);

	char_decoder u_decode (
		.rx_data(rx_data), .rx_valid(rx_valid), .is_hex(is_hex), .hex_val(hex_val),
		.is_cmd(is_cmd), .cmd_kind(cmd_kind), .is_eol(is_eol)
	);

	command_engine u_exec (
		.clk(clk), .reset(reset), .is_hex(is_hex), .hex_val(hex_val),
		.is_cmd(is_cmd), .cmd_kind(cmd_kind), .is_eol(is_eol),
		.tgt_byte(tgt_byte), .tgt_kind(tgt_kind),
		.tgt_byte_valid(tgt_byte_valid), .tgt_msg_end(tgt_msg_end)
	);

	// Full flag stays internal, the FIFO drops on overflow itself
	byte_fifo u_fifo (
		.clk(clk), .reset(reset), .wr_data(rsp_byte), .wr_en(rsp_valid),
		.rd_data(rd_data), .rd_en(rd_en), .empty(empty), .full()
	);

	response_formatter u_result (
		.clk(clk), .reset(reset), .rsp_end(rsp_end), .rd_data(rd_data),
		.empty(empty), .rd_en(rd_en), .tx_data(tx_data),
		.tx_start(tx_start), .tx_busy(tx_busy)
	);

endmodule

`default_nettype wire

//--- design/response_formatter.sv
`timescale 1ns/100ps
`default_nettype none
`include "bridge_config.svh"

module response_formatter import bridge_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       rsp_end,
	input  logic [7:0] rd_data,
	input  logic       empty,
	output logic       rd_en,
	output logic [7:0] tx_data,
	output logic       tx_start,
	input  logic       tx_busy
);

	rsp_state_t state;
	rsp_state_t next_state;
	logic       low_nib;
	logic       pend_end;

	// Lower-case ASCII for one nibble
	function automatic logic [7:0] hex_char(input logic [3:0] n);
		return (n < 4'd10) ? 8'h30 + {4'h0, n} : 8'h57 + {4'h0, n};
	endfunction

	always_comb begin
		next_state = state;
		tx_start = 1'b0;
		tx_data = 8'h00;
		rd_en = 1'b0;
		case (state)
			RS_IDLE: begin
				if (rsp_end || pend_end)
					next_state = RS_PREFIX;
			end
			RS_PREFIX: begin
				tx_data = `RSP_PREFIX;
				if (!tx_busy) begin
					tx_start = 1'b1;
					next_state = RS_HEX;
				end
			end
			RS_HEX: begin
				tx_data = hex_char(low_nib ? rd_data[3:0] : rd_data[7:4]);
				if (!tx_busy) begin
					// Empty at the start of a byte closes the line
					if (!low_nib && empty) begin
						next_state = RS_EOL;
					end else begin
						tx_start = 1'b1;
						rd_en = low_nib;
					end
				end
			end
			RS_EOL: begin
				tx_data = `CHAR_LF;
				if (!tx_busy) begin
					tx_start = 1'b1;
					next_state = RS_IDLE;
				end
			end
			default: next_state = RS_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RS_IDLE;
			low_nib <= 1'b0;
			pend_end <= 1'b0;
		end else begin
			state <= next_state;
			if (state == RS_IDLE)
				pend_end <= 1'b0;
			else if (rsp_end)
				pend_end <= 1'b1;
			if (state == RS_PREFIX)
				low_nib <= 1'b0;
			else if (state == RS_HEX && tx_start)
				low_nib <= !low_nib;
		end
	end

	// Transmitter must take every character the cycle it is offered
	a_start_taken: assert property (@(posedge clk) disable iff (reset)
		tx_start |=> tx_busy);

endmodule

`default_nettype wire

//--- design/byte_fifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "bridge_config.svh"

module byte_fifo (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] wr_data,
	input  logic       wr_en,
	output logic [7:0] rd_data,
	input  logic       rd_en,
	output logic       empty,
	output logic       full
);

	logic [7:0]            mem [`FIFO_DEPTH];
	logic [`FIFO_AW-1:0]   wr_ptr;
	logic [`FIFO_AW-1:0]   rd_ptr;
	logic [`FIFO_AW:0]     count;
	logic                  do_wr;
	logic                  do_rd;

	// Writes to a full FIFO are lost
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (do_wr ? 1'b1 : 1'b0) - (do_rd ? 1'b1 : 1'b0);
		end
	end

	// Head entry is visible before the pop
	assign rd_data = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == (`FIFO_AW+1)'(`FIFO_DEPTH));

	a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
		rd_en |-> !empty);

endmodule

`default_nettype wire

//--- design/command_engine.sv
`timescale 1ns/100ps
`default_nettype none

module command_engine import bridge_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       is_hex,
	input  logic [3:0] hex_val,
	input  logic       is_cmd,
	input  cmd_kind_t  cmd_kind,
	input  logic       is_eol,
	output logic [7:0] tgt_byte,
	output cmd_kind_t  tgt_kind,
	output logic       tgt_byte_valid,
	output logic       tgt_msg_end
);

	exec_state_t state;
	cmd_kind_t   line_kind;
	logic [3:0]  hi_nib;
	logic        half;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= EX_IDLE;
			half <= 1'b0;
			tgt_byte_valid <= 1'b0;
			tgt_msg_end <= 1'b0;
		end else begin
			tgt_byte_valid <= 1'b0;
			tgt_msg_end <= 1'b0;
			if (is_cmd) begin
				// New letter restarts the line from any state
				line_kind <= cmd_kind;
				half <= 1'b0;
				state <= EX_COLLECT;
			end else begin
				case (state)
					EX_IDLE: begin
						// Stray digits and newlines before a command are dropped
					end
					EX_COLLECT: begin
						if (is_hex) begin
							if (half) begin
								tgt_byte <= {hi_nib, hex_val};
								tgt_kind <= line_kind;
								tgt_byte_valid <= 1'b1;
								half <= 1'b0;
							end else begin
								hi_nib <= hex_val;
								half <= 1'b1;
							end
						end else if (is_eol) begin
							// Odd digit count pads the low nibble
							if (half) begin
								tgt_byte <= {hi_nib, 4'h0};
								tgt_kind <= line_kind;
								tgt_byte_valid <= 1'b1;
							end
							tgt_msg_end <= 1'b1;
							half <= 1'b0;
							state <= EX_FLUSH;
						end
					end
					EX_FLUSH: state <= EX_IDLE;
					default: state <= EX_IDLE;
				endcase
			end
		end
	end

	// A digit or newline landing in the flush cycle would be lost
	a_no_char_in_flush: assert property (@(posedge clk) disable iff (reset)
		state == EX_FLUSH |-> !is_hex && !is_eol);

endmodule

`default_nettype wire

//--- design/char_decoder.sv
`timescale 1ns/100ps
`default_nettype none
`include "bridge_config.svh"

module char_decoder import bridge_pkg::*; (
	input  logic [7:0] rx_data,
	input  logic       rx_valid,
	output logic       is_hex,
	output logic [3:0] hex_val,
	output logic       is_cmd,
	output cmd_kind_t  cmd_kind,
	output logic       is_eol
);

	always_comb begin
		is_hex = 1'b0;
		hex_val = 4'h0;
		is_cmd = 1'b0;
		cmd_kind = CMD_WRITE;
		is_eol = 1'b0;
		if (rx_valid) begin
			// Command letters take priority over the lower-case digits 'a' and 'c'
			if (rx_data == "w") begin
				is_cmd = 1'b1;
				cmd_kind = CMD_WRITE;
			end else if (rx_data == "c") begin
				is_cmd = 1'b1;
				cmd_kind = CMD_CTRL;
			end else if (rx_data == "a") begin
				is_cmd = 1'b1;
				cmd_kind = CMD_ADDR;
			end else if (rx_data >= "0" && rx_data <= "9") begin
				is_hex = 1'b1;
				hex_val = 4'(rx_data - 8'h30);
			end else if (rx_data >= "a" && rx_data <= "f") begin
				is_hex = 1'b1;
				hex_val = 4'(rx_data - 8'h57);
			end else if (rx_data >= "A" && rx_data <= "F") begin
				is_hex = 1'b1;
				hex_val = 4'(rx_data - 8'h37);
			end else if (rx_data == `CHAR_LF) begin
				is_eol = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/uart_link.sv
`timescale 1ns/100ps
`default_nettype none
`include "bridge_config.svh"

module uart_link (
	input  logic       clk,
	input  logic       reset,
	input  logic       rxd,
	output logic       txd,
	output logic [7:0] rx_data,
	output logic       rx_valid,
	input  logic [7:0] tx_data,
	input  logic       tx_start,
	output logic       tx_busy
);
	localparam int CW = $clog2(`BAUD_DIV + 1);
	localparam logic [CW-1:0] BIT_LAST = CW'(`BAUD_DIV - 1);
	localparam logic [CW-1:0] HALF_BIT = CW'(`BAUD_DIV / 2 - 1);

	logic          rx_meta;
	logic          rx_sync;
	logic          rx_active;
	logic [CW-1:0] rx_cnt;
	logic [3:0]    rx_bit;
	logic [7:0]    rx_shift;
	logic [CW-1:0] tx_cnt;
	logic [3:0]    tx_bit;
	logic [9:0]    tx_shift;

	// Two-flop synchronizer, line idles high
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
		end
	end

	// Receiver timing: half a bit to the middle of start, then whole bits
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_active <= 1'b0;
			rx_valid <= 1'b0;
			rx_cnt <= '0;
			rx_bit <= '0;
		end else begin
			rx_valid <= 1'b0;
			if (!rx_active) begin
				if (!rx_sync) begin
					rx_active <= 1'b1;
					rx_cnt <= HALF_BIT;
					rx_bit <= 4'd0;
				end
			end else if (rx_cnt != '0) begin
				rx_cnt <= rx_cnt - 1'b1;
			end else begin
				rx_cnt <= BIT_LAST;
				rx_bit <= rx_bit + 4'd1;
				if (rx_bit == 4'd0) begin
					// Line back high at mid start bit, just a glitch
					if (rx_sync)
						rx_active <= 1'b0;
				end else if (rx_bit == 4'd9) begin
					rx_active <= 1'b0;
					// Framing error drops the character
					rx_valid <= rx_sync;
				end
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk) begin
		if (rx_active && rx_cnt == '0 && rx_bit >= 4'd1 && rx_bit <= 4'd8)
			rx_shift <= {rx_sync, rx_shift[7:1]};
	end

	// Shift register holds the byte until the next frame starts
	assign rx_data = rx_shift;

	// Transmitter: ten bit times per frame
	always_ff @(posedge clk) begin
		if (reset) begin
			tx_busy <= 1'b0;
			tx_cnt <= '0;
			tx_bit <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_busy <= 1'b1;
				tx_cnt <= BIT_LAST;
				tx_bit <= 4'd0;
			end
		end else if (tx_cnt != '0) begin
			tx_cnt <= tx_cnt - 1'b1;
		end else begin
			tx_cnt <= BIT_LAST;
			tx_bit <= tx_bit + 4'd1;
			if (tx_bit == 4'd9)
				tx_busy <= 1'b0;
		end
	end

	// Frame is stop, data, start; shifts in ones behind it
	always_ff @(posedge clk) begin
		if (!tx_busy && tx_start)
			tx_shift <= {1'b1, tx_data, 1'b0};
		else if (tx_busy && tx_cnt == '0)
			tx_shift <= {1'b1, tx_shift[9:1]};
	end

	assign txd = tx_busy ? tx_shift[0] : 1'b1;

	a_no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
		!(tx_start && tx_busy));

endmodule

`default_nettype wire

//--- design/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

	// Kind of a command line, from its leading letter
	typedef enum logic [1:0] {
		CMD_WRITE = 2'd0,
		CMD_CTRL  = 2'd1,
		CMD_ADDR  = 2'd2
	} cmd_kind_t;

	// Execute stage FSM
	typedef enum logic [1:0] {
		EX_IDLE    = 2'd0,
		EX_COLLECT = 2'd1,
		EX_FLUSH   = 2'd2
	} exec_state_t;

	// Result stage FSM
	typedef enum logic [1:0] {
		RS_IDLE   = 2'd0,
		RS_PREFIX = 2'd1,
		RS_HEX    = 2'd2,
		RS_EOL    = 2'd3
	} rsp_state_t;

endpackage

`default_nettype wire

//--- design/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// Clocks per UART bit, kept short for simulation
`define BAUD_DIV 8

// Response FIFO geometry
`define FIFO_DEPTH 16
`define FIFO_AW 4

// ASCII 'r' leads every response line
`define RSP_PREFIX 8'h72

// Line terminator in both directions
`define CHAR_LF 8'h0a

`endif
